// ==== rtl/rv64_pkg.sv ====
`default_nettype none

package rv64_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_addr_t;

    localparam int DMEM_BYTES = 1024;
    localparam int DMEM_AW    = $clog2(DMEM_BYTES);

    typedef logic [DMEM_AW-1:0] dmem_addr_t; // Byte index, wraps at DMEM_BYTES

    localparam xlen_t RESET_PC = '0;

    // Write-back source select
    localparam logic [1:0] WB_ALU  = 2'd0;
    localparam logic [1:0] WB_LOAD = 2'd1;
    localparam logic [1:0] WB_PC4  = 2'd2;

    // Major opcodes of the kept RV64I subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLT    = 4'd2,
        ALU_SLTU   = 4'd3,
        ALU_AND    = 4'd4,
        ALU_OR     = 4'd5,
        ALU_XOR    = 4'd6,
        ALU_SLL    = 4'd7,
        ALU_SRL    = 4'd8,
        ALU_SRA    = 4'd9,
        ALU_PASS_B = 4'd10 // LUI
    } alu_op_e;

    // Branch funct3 encodings
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_e;

endpackage

`default_nettype wire

// ==== rtl/rv64_decoder.sv ====
`default_nettype none

module rv64_decoder (
    input  wire rv64_pkg::instr_t instr,
    input  wire                   reset_n,
    output rv64_pkg::reg_addr_t   rs1_addr,
    output rv64_pkg::reg_addr_t   rs2_addr,
    output rv64_pkg::reg_addr_t   rd_addr,
    output logic                  rd_write,
    output rv64_pkg::alu_op_e     alu_op,
    output logic                  alu_src_imm,
    output logic                  pc_src,
    output rv64_pkg::xlen_t       imm,
    output logic                  load,
    output logic                  store,
    output logic [2:0]            mem_size,
    output logic                  branch,
    output rv64_pkg::branch_e     branch_kind,
    output logic                  jump,
    output logic                  jump_reg,
    output logic [1:0]            wb_sel
);

    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            writes_rd;
    rv64_pkg::xlen_t imm_i;
    rv64_pkg::xlen_t imm_s;
    rv64_pkg::xlen_t imm_b;
    rv64_pkg::xlen_t imm_u;
    rv64_pkg::xlen_t imm_j;

    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign rd_addr  = instr[11:7];

    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    assign mem_size    = funct3; // Raw size and unsigned flag
    assign branch_kind = rv64_pkg::branch_e'(funct3);

    always_comb begin
        writes_rd   = 1'b0;
        alu_op      = rv64_pkg::ALU_ADD;
        alu_src_imm = 1'b0;
        pc_src      = 1'b0;
        imm         = '0;
        load        = 1'b0;
        store       = 1'b0;
        branch      = 1'b0;
        jump        = 1'b0;
        jump_reg    = 1'b0;
        wb_sel      = rv64_pkg::WB_ALU;
        case (rv64_pkg::opcode_e'(instr[6:0]))
            rv64_pkg::OPC_LUI: begin
                writes_rd   = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = rv64_pkg::ALU_PASS_B;
                imm         = imm_u;
            end
            rv64_pkg::OPC_AUIPC: begin
                writes_rd   = 1'b1;
                alu_src_imm = 1'b1;
                pc_src      = 1'b1;
                imm         = imm_u;
            end
            rv64_pkg::OPC_JAL: begin
                writes_rd = 1'b1;
                jump      = 1'b1;
                imm       = imm_j;
                wb_sel    = rv64_pkg::WB_PC4;
            end
            rv64_pkg::OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    writes_rd = 1'b1;
                    jump      = 1'b1;
                    jump_reg  = 1'b1;
                    imm       = imm_i;
                    wb_sel    = rv64_pkg::WB_PC4;
                end
            end
            rv64_pkg::OPC_BRANCH: begin
                branch = (funct3[2:1] != 2'b01); // 010 and 011 are reserved
                imm    = imm_b;
            end
            rv64_pkg::OPC_LOAD: begin
                if (funct3 != 3'b111) begin
                    writes_rd   = 1'b1;
                    load        = 1'b1;
                    alu_src_imm = 1'b1;
                    imm         = imm_i;
                    wb_sel      = rv64_pkg::WB_LOAD;
                end
            end
            rv64_pkg::OPC_STORE: begin
                store       = ~funct3[2];
                alu_src_imm = 1'b1;
                imm         = imm_s;
            end
            rv64_pkg::OPC_OP_IMM: begin
                writes_rd   = 1'b1;
                alu_src_imm = 1'b1;
                imm         = imm_i;
                case (funct3)
                    3'b000: alu_op = rv64_pkg::ALU_ADD;
                    3'b010: alu_op = rv64_pkg::ALU_SLT;
                    3'b011: alu_op = rv64_pkg::ALU_SLTU;
                    3'b100: alu_op = rv64_pkg::ALU_XOR;
                    3'b110: alu_op = rv64_pkg::ALU_OR;
                    3'b111: alu_op = rv64_pkg::ALU_AND;
                    3'b001: begin
                        alu_op    = rv64_pkg::ALU_SLL;
                        writes_rd = (funct7[6:1] == 6'b000000);
                    end
                    default: begin // 3'b101, SRLI or SRAI
                        alu_op    = funct7[5] ? rv64_pkg::ALU_SRA : rv64_pkg::ALU_SRL;
                        writes_rd = ({funct7[6], funct7[4:1]} == 5'b00000);
                    end
                endcase
            end
            rv64_pkg::OPC_OP: begin
                writes_rd = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: alu_op = rv64_pkg::ALU_ADD;
                    {7'h20, 3'b000}: alu_op = rv64_pkg::ALU_SUB;
                    {7'h00, 3'b001}: alu_op = rv64_pkg::ALU_SLL;
                    {7'h00, 3'b010}: alu_op = rv64_pkg::ALU_SLT;
                    {7'h00, 3'b011}: alu_op = rv64_pkg::ALU_SLTU;
                    {7'h00, 3'b100}: alu_op = rv64_pkg::ALU_XOR;
                    {7'h00, 3'b101}: alu_op = rv64_pkg::ALU_SRL;
                    {7'h20, 3'b101}: alu_op = rv64_pkg::ALU_SRA;
                    {7'h00, 3'b110}: alu_op = rv64_pkg::ALU_OR;
                    {7'h00, 3'b111}: alu_op = rv64_pkg::ALU_AND;
                    default:         writes_rd = 1'b0;
                endcase
            end
            default: ; // Not kept, runs as a no-op
        endcase
        if (!reset_n) begin
            load     = 1'b0;
            store    = 1'b0;
            branch   = 1'b0;
            jump     = 1'b0;
            jump_reg = 1'b0;
        end
    end

    assign rd_write = writes_rd && (rd_addr != '0) && reset_n;

endmodule

`default_nettype wire

// ==== rtl/rv64_regfile.sv ====
`default_nettype none

module rv64_regfile (
    input  wire                      clock,
    input  wire                      reset_n,
    input  wire rv64_pkg::reg_addr_t rs1_addr,
    input  wire rv64_pkg::reg_addr_t rs2_addr,
    input  wire rv64_pkg::reg_addr_t rd_addr,
    input  wire                      rd_write,
    input  wire rv64_pkg::xlen_t     rd_data,
    output rv64_pkg::xlen_t          rs1_data,
    output rv64_pkg::xlen_t          rs2_data
);

    rv64_pkg::xlen_t regs [32];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_write && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr]; // x0 is hardwired
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // Decoder must already filter writes to x0
    no_x0_write: assert property (
        @(posedge clock) disable iff (!reset_n) rd_write |-> (rd_addr != '0)
    );

endmodule

`default_nettype wire

// ==== rtl/rv64_alu.sv ====
`default_nettype none

module rv64_alu (
    input  wire rv64_pkg::alu_op_e alu_op,
    input  wire rv64_pkg::xlen_t   a,
    input  wire rv64_pkg::xlen_t   b,
    output rv64_pkg::xlen_t        result
);

    logic [5:0] shamt;

    assign shamt = b[5:0]; // RV64 shift amount

    always_comb begin
        case (alu_op)
            rv64_pkg::ALU_ADD: begin
                result = a + b;
            end
            rv64_pkg::ALU_SUB: begin
                result = a - b;
            end
            rv64_pkg::ALU_SLT: begin
                result = rv64_pkg::xlen_t'($signed(a) < $signed(b));
            end
            rv64_pkg::ALU_SLTU: begin
                result = rv64_pkg::xlen_t'(a < b);
            end
            rv64_pkg::ALU_AND: begin
                result = a & b;
            end
            rv64_pkg::ALU_OR: begin
                result = a | b;
            end
            rv64_pkg::ALU_XOR: begin
                result = a ^ b;
            end
            rv64_pkg::ALU_SLL: begin
                result = a << shamt;
            end
            rv64_pkg::ALU_SRL: begin
                result = a >> shamt;
            end
            rv64_pkg::ALU_SRA: begin
                result = $signed(a) >>> shamt;
            end
            rv64_pkg::ALU_PASS_B: begin
                result = b; // Upper immediate for LUI
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/rv64_lsu.sv ====
`default_nettype none

module rv64_lsu (
    input  wire                  clock,
    input  wire                  reset_n,
    input  wire                  load,
    input  wire                  store,
    input  wire [2:0]            mem_size,
    input  wire rv64_pkg::xlen_t addr,
    input  wire rv64_pkg::xlen_t store_data,
    output rv64_pkg::xlen_t      load_data
);

    logic [7:0]           mem [rv64_pkg::DMEM_BYTES]; // Little-endian bytes
    rv64_pkg::dmem_addr_t base;
    rv64_pkg::xlen_t      raw;
    logic [3:0]           nbytes;

    assign base   = addr[rv64_pkg::DMEM_AW-1:0]; // Upper bits ignored, address wraps
    assign nbytes = 4'd1 << mem_size[1:0];

    // Eight bytes from base, wrapping at the end of memory
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            raw[8*i +: 8] = mem[base + rv64_pkg::dmem_addr_t'(i)];
        end
    end

    always_comb begin
        case (mem_size)
            3'b000:  load_data = {{56{raw[7]}}, raw[7:0]};   // LB
            3'b001:  load_data = {{48{raw[15]}}, raw[15:0]}; // LH
            3'b010:  load_data = {{32{raw[31]}}, raw[31:0]}; // LW
            3'b011:  load_data = raw;                        // LD
            3'b100:  load_data = {56'b0, raw[7:0]};          // LBU
            3'b101:  load_data = {48'b0, raw[15:0]};         // LHU
            3'b110:  load_data = {32'b0, raw[31:0]};         // LWU
            default: load_data = '0;
        endcase
        if (!load) begin
            load_data = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (store) begin
            for (int i = 0; i < 8; i++) begin
                if (i < nbytes) begin
                    mem[base + rv64_pkg::dmem_addr_t'(i)] <= store_data[8*i +: 8];
                end
            end
        end
    end

    // Store enable comes from the decoder, which holds it low in reset
    no_store_in_reset: assert property (
        @(posedge clock) !reset_n |-> !store
    );

    no_load_and_store: assert property (
        @(posedge clock) disable iff (!reset_n) !(load && store)
    );

endmodule

`default_nettype wire

// ==== rtl/rv64_fetch.sv ====
`default_nettype none

module rv64_fetch (
    input  wire                    clock,
    input  wire                    reset_n,
    input  wire                    branch,
    input  wire rv64_pkg::branch_e branch_kind,
    input  wire                    jump,
    input  wire                    jump_reg,
    input  wire rv64_pkg::xlen_t   imm,
    input  wire rv64_pkg::xlen_t   rs1_data,
    input  wire rv64_pkg::xlen_t   rs2_data,
    output rv64_pkg::xlen_t        pc,
    output rv64_pkg::xlen_t        pc_plus4
);

    rv64_pkg::xlen_t pc_next;
    logic            taken;

    assign pc_plus4 = pc + 64'd4;

    always_comb begin
        case (branch_kind)
            rv64_pkg::BR_EQ:  taken = (rs1_data == rs2_data);
            rv64_pkg::BR_NE:  taken = (rs1_data != rs2_data);
            rv64_pkg::BR_LT:  taken = ($signed(rs1_data) < $signed(rs2_data));
            rv64_pkg::BR_GE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            rv64_pkg::BR_LTU: taken = (rs1_data < rs2_data);
            rv64_pkg::BR_GEU: taken = (rs1_data >= rs2_data);
            default:          taken = 1'b0;
        endcase
    end

    always_comb begin
        if (jump_reg) begin
            pc_next = (rs1_data + imm) & ~64'd1; // JALR clears bit 0
        end else if (jump || (branch && taken)) begin
            pc_next = pc + imm;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pc <= rv64_pkg::RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    pc_halfword_aligned: assert property (
        @(posedge clock) disable iff (!reset_n) pc[0] == 1'b0
    );

endmodule

`default_nettype wire

// ==== rtl/rv64_core.sv ====
`default_nettype none

module rv64_core (
    input  wire                   clock,
    input  wire                   reset_n,
    input  wire rv64_pkg::instr_t instr,
    output rv64_pkg::xlen_t       pc,
    output logic                  rd_write,
    output rv64_pkg::reg_addr_t   rd_addr,
    output rv64_pkg::xlen_t       rd_data
);

    rv64_pkg::reg_addr_t rs1_addr;
    rv64_pkg::reg_addr_t rs2_addr;
    rv64_pkg::alu_op_e   alu_op;
    rv64_pkg::branch_e   branch_kind;
    rv64_pkg::xlen_t     imm;
    rv64_pkg::xlen_t     rs1_data;
    rv64_pkg::xlen_t     rs2_data;
    rv64_pkg::xlen_t     alu_a;
    rv64_pkg::xlen_t     alu_b;
    rv64_pkg::xlen_t     alu_result;
    rv64_pkg::xlen_t     load_data;
    rv64_pkg::xlen_t     pc_plus4;
    logic                alu_src_imm;
    logic                pc_src;
    logic                load;
    logic                store;
    logic [2:0]          mem_size;
    logic                branch;
    logic                jump;
    logic                jump_reg;
    logic [1:0]          wb_sel;

    rv64_decoder u_decoder (
        .instr       (instr),
        .reset_n     (reset_n),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rd_addr     (rd_addr),
        .rd_write    (rd_write),
        .alu_op      (alu_op),
        .alu_src_imm (alu_src_imm),
        .pc_src      (pc_src),
        .imm         (imm),
        .load        (load),
        .store       (store),
        .mem_size    (mem_size),
        .branch      (branch),
        .branch_kind (branch_kind),
        .jump        (jump),
        .jump_reg    (jump_reg),
        .wb_sel      (wb_sel)
    );

    rv64_regfile u_regfile (
        .clock    (clock),
        .reset_n  (reset_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (rd_addr),
        .rd_write (rd_write),
        .rd_data  (rd_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign alu_a = pc_src ? pc : rs1_data;       // AUIPC adds to pc
    assign alu_b = alu_src_imm ? imm : rs2_data;

    rv64_alu u_alu (
        .alu_op (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    rv64_lsu u_lsu (
        .clock      (clock),
        .reset_n    (reset_n),
        .load       (load),
        .store      (store),
        .mem_size   (mem_size),
        .addr       (alu_result),
        .store_data (rs2_data),
        .load_data  (load_data)
    );

    rv64_fetch u_fetch (
        .clock       (clock),
        .reset_n     (reset_n),
        .branch      (branch),
        .branch_kind (branch_kind),
        .jump        (jump),
        .jump_reg    (jump_reg),
        .imm         (imm),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .pc          (pc),
        .pc_plus4    (pc_plus4)
    );

    always_comb begin
        case (wb_sel)
            rv64_pkg::WB_LOAD: rd_data = load_data;
            rv64_pkg::WB_PC4:  rd_data = pc_plus4; // Link address
            default:           rd_data = alu_result;
        endcase
    end

endmodule

`default_nettype wire

// ==== verif/rv64_tb.sv ====
`default_nettype none

module rv64_tb;

    localparam int               PROG_LEN       = 300;
    localparam int               TIMEOUT_CYCLES = PROG_LEN * 2 + 50;
    localparam rv64_pkg::xlen_t  END_PC         = PROG_LEN * 4;
    localparam rv64_pkg::instr_t NOP            = 32'h0000_0013;  // ADDI x0, x0, 0
    localparam logic [4:0]       BASE_REG       = 5'd30;          // Data memory base
    localparam logic [4:0]       LINK_REG       = 5'd29;          // JALR target holder

    logic                clock;
    logic                reset_n;
    rv64_pkg::instr_t    instr;
    rv64_pkg::xlen_t     pc;
    logic                rd_write;
    rv64_pkg::reg_addr_t rd_addr;
    rv64_pkg::xlen_t     rd_data;

    rv64_pkg::instr_t prog [PROG_LEN];
    int               n_prog;
    logic [31:0]      rng;
    int               mismatches;

    // Reference machine state
    rv64_pkg::xlen_t m_regs [32];
    logic [7:0]      m_mem [rv64_pkg::DMEM_BYTES];
    rv64_pkg::xlen_t m_pc;

    rv64_core DUT (
        .clock    (clock),
        .reset_n  (reset_n),
        .instr    (instr),
        .pc       (pc),
        .rd_write (rd_write),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        rng = xorshift(rng);
        return rng % n;
    endfunction

    function automatic rv64_pkg::reg_addr_t rand_reg();
        return rv64_pkg::reg_addr_t'(rand_below(16)); // x0..x15, x0 included
    endfunction

    function automatic rv64_pkg::instr_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv64_pkg::OPC_OP};
    endfunction

    function automatic rv64_pkg::instr_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv64_pkg::instr_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rv64_pkg::OPC_STORE};
    endfunction

    function automatic rv64_pkg::instr_t enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv64_pkg::OPC_BRANCH};
    endfunction

    function automatic rv64_pkg::instr_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                               input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic rv64_pkg::instr_t enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv64_pkg::OPC_JAL};
    endfunction

    task automatic emit(input rv64_pkg::instr_t w);
        prog[n_prog] = w;
        n_prog++;
    endtask

    task automatic emit_alu();
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        f3 = 3'(rand_below(8));
        if (rand_below(2) == 0) begin
            f7 = ((f3 == 3'b000 || f3 == 3'b101) && rand_below(2) == 1) ? 7'h20 : 7'h00;
            emit(enc_r(f7, rand_reg(), rand_reg(), f3, rand_reg()));
        end else begin
            imm = 12'(rand_below(4096));
            if (f3 == 3'b001) begin
                imm = 12'(rand_below(64));
            end else if (f3 == 3'b101) begin
                imm = {1'b0, 1'(rand_below(2)), 4'b0, 6'(rand_below(64))}; // SRLI or SRAI
            end
            emit(enc_i(imm, rand_reg(), f3, rand_reg(), rv64_pkg::OPC_OP_IMM));
        end
    endtask

    // Forward-only control flow, so the program always runs off its end
    task automatic build_program();
        int unsigned         kind;
        int unsigned         skip;
        int unsigned         size;
        int unsigned         off;
        int unsigned         lsize;
        logic                uns;
        logic [2:0]          f3;
        logic [6:0]          opc;
        rv64_pkg::reg_addr_t rs1;
        rv64_pkg::reg_addr_t rs2;
        n_prog = 0;
        rng    = 32'h3cbb;
        emit(NOP);
        emit(enc_i(12'd256, 5'd0, 3'b000, BASE_REG, rv64_pkg::OPC_OP_IMM));
        for (int r = 1; r < 16; r++) begin
            emit(enc_u(20'(rand_below(1 << 20)), 5'(r), rv64_pkg::OPC_LUI));
        end
        while (n_prog < PROG_LEN - 8) begin
            kind = rand_below(10);
            skip = rand_below(4);
            case (kind)
                0, 1, 2: emit_alu();
                3: begin
                    opc = (rand_below(2) == 0) ? rv64_pkg::OPC_LUI : rv64_pkg::OPC_AUIPC;
                    emit(enc_u(20'(rand_below(1 << 20)), rand_reg(), opc));
                end
                4, 5: begin
                    size = rand_below(4);
                    off  = 8 * rand_below(128);
                    emit(enc_s(12'(off - 256), rand_reg(), BASE_REG, 3'(size)));
                    lsize = rand_below(size + 1); // Never wider than the store
                    uns   = (lsize < 3) && (rand_below(2) == 1);
                    emit(enc_i(12'(off - 256), BASE_REG, {uns, 2'(lsize)}, rand_reg(),
                               rv64_pkg::OPC_LOAD));
                end
                6: begin
                    f3 = 3'(rand_below(6));
                    if (f3 > 3'd1) begin
                        f3 = f3 + 3'd2;
                    end
                    rs1 = rand_reg();
                    rs2 = (rand_below(4) == 0) ? rs1 : rand_reg();
                    emit(enc_b(13'(4 * (skip + 1)), rs2, rs1, f3));
                    repeat (skip) emit_alu();
                end
                7: begin
                    emit(enc_j(21'(4 * (skip + 1)), rand_reg()));
                    repeat (skip) emit_alu();
                end
                8: begin
                    emit(enc_i(12'(4 * (n_prog + 2 + skip)), 5'd0, 3'b000, LINK_REG,
                               rv64_pkg::OPC_OP_IMM));
                    emit(enc_i(12'(rand_below(2)), LINK_REG, 3'b000, rand_reg(),
                               rv64_pkg::OPC_JALR)); // Odd offset tests bit 0 clear
                    repeat (skip) emit_alu();
                end
                default: begin
                    case (rand_below(4))
                        0: opc = 7'h0f;       // FENCE
                        1: opc = 7'h73;       // SYSTEM
                        2: opc = 7'h1b;       // OP-IMM-32
                        default: opc = 7'h3b; // OP-32
                    endcase
                    emit({25'(rand_below(1 << 25)), opc});
                end
            endcase
        end
        while (n_prog < PROG_LEN) begin
            emit(NOP);
        end
    endtask

    function automatic rv64_pkg::instr_t fetch_word(input rv64_pkg::xlen_t addr);
        if (addr < END_PC) begin
            return prog[int'(addr >> 2)];
        end
        return NOP;
    endfunction

    function automatic rv64_pkg::xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                                input rv64_pkg::xlen_t x,
                                                input rv64_pkg::xlen_t y);
        logic signed [63:0] sx;
        logic signed [63:0] sy;
        logic [5:0]         sh;
        sx = x;
        sy = y;
        sh = y[5:0];
        case (f3)
            3'b000: return alt ? x - y : x + y;
            3'b001: return x << sh;
            3'b010: return {63'b0, sx < sy};
            3'b011: return {63'b0, x < y};
            3'b100: return x ^ y;
            3'b101: begin
                if (alt) begin
                    return sx >>> sh;
                end
                return x >> sh;
            end
            3'b110: return x | y;
            default: return x & y;
        endcase
    endfunction

    // One instruction of the ISA on the model state
    function automatic void iss_step(input  rv64_pkg::instr_t    ins,
                                     output rv64_pkg::xlen_t     cur_pc,
                                     output logic                wr,
                                     output rv64_pkg::reg_addr_t rd,
                                     output rv64_pkg::xlen_t     val);
        logic signed [63:0] sx;
        logic signed [63:0] ext;
        rv64_pkg::xlen_t    i_imm;
        rv64_pkg::xlen_t    s_imm;
        rv64_pkg::xlen_t    b_imm;
        rv64_pkg::xlen_t    j_imm;
        rv64_pkg::xlen_t    u_imm;
        rv64_pkg::xlen_t    sgn;
        rv64_pkg::xlen_t    a;
        rv64_pkg::xlen_t    b;
        rv64_pkg::xlen_t    addr;
        rv64_pkg::xlen_t    next_pc;
        logic [2:0]         f3;
        logic               cond;
        int                 nbytes;
        f3      = ins[14:12];
        rd      = ins[11:7];
        a       = m_regs[ins[19:15]];
        b       = m_regs[ins[24:20]];
        sx      = $signed(ins);
        i_imm   = sx >>> 20;
        u_imm   = (sx >>> 12) << 12;
        sgn     = sx >>> 63;
        s_imm   = (i_imm & ~64'h1f) | 64'(ins[11:7]);
        b_imm   = (sgn << 12) | (64'(ins[7]) << 11) | (64'(ins[30:25]) << 5)
                | (64'(ins[11:8]) << 1);
        j_imm   = (sgn << 20) | (64'(ins[19:12]) << 12) | (64'(ins[20]) << 11)
                | (64'(ins[30:21]) << 1);
        cur_pc  = m_pc;
        next_pc = m_pc + 64'd4;
        wr      = 1'b0;
        val     = '0;
        nbytes  = 1 << f3[1:0];
        case (ins[6:0])
            rv64_pkg::OPC_LUI: begin
                wr  = 1'b1;
                val = u_imm;
            end
            rv64_pkg::OPC_AUIPC: begin
                wr  = 1'b1;
                val = m_pc + u_imm;
            end
            rv64_pkg::OPC_JAL: begin
                wr      = 1'b1;
                val     = m_pc + 64'd4;
                next_pc = m_pc + j_imm;
            end
            rv64_pkg::OPC_JALR: begin
                if (f3 == 3'b000) begin
                    wr      = 1'b1;
                    val     = m_pc + 64'd4;
                    next_pc = (a + i_imm) & ~64'd1;
                end
            end
            rv64_pkg::OPC_BRANCH: begin
                case (f3[2:1])
                    2'b00: cond = (a == b);
                    2'b10: cond = ($signed(a) < $signed(b));
                    2'b11: cond = (a < b);
                    default: cond = 1'b0;
                endcase
                if (f3[2:1] != 2'b01 && (cond ^ f3[0])) begin // Odd funct3 inverts
                    next_pc = m_pc + b_imm;
                end
            end
            rv64_pkg::OPC_LOAD: begin
                if (f3 != 3'b111) begin
                    addr = a + i_imm;
                    for (int k = 0; k < nbytes; k++) begin
                        val = val | (64'(m_mem[int'((addr + 64'(k)) % rv64_pkg::DMEM_BYTES)])
                                     << (8 * k));
                    end
                    ext = val << (64 - 8 * nbytes);
                    if (!f3[2]) begin
                        val = ext >>> (64 - 8 * nbytes);
                    end
                    wr = 1'b1;
                end
            end
            rv64_pkg::OPC_STORE: begin
                if (!f3[2]) begin
                    addr = a + s_imm;
                    for (int k = 0; k < nbytes; k++) begin
                        m_mem[int'((addr + 64'(k)) % rv64_pkg::DMEM_BYTES)] = b[8*k +: 8];
                    end
                end
            end
            rv64_pkg::OPC_OP: begin
                wr  = (ins[31:25] == 7'h00)
                   || (ins[31:25] == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
                val = alu_ref(f3, ins[30], a, b);
            end
            rv64_pkg::OPC_OP_IMM: begin
                wr = 1'b1;
                if (f3 == 3'b001) begin
                    wr = (ins[31:26] == 6'h00);
                end else if (f3 == 3'b101) begin
                    wr = (ins[31:26] == 6'h00) || (ins[31:26] == 6'h10);
                end
                val = alu_ref(f3, ins[30] && f3 == 3'b101, a, i_imm);
            end
            default: ; // Dropped encodings retire as no-ops
        endcase
        wr = wr && (rd != 5'd0);
        if (wr) begin
            m_regs[rd] = val;
        end
        m_pc = next_pc;
    endfunction

    task automatic stop_on_error();
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first mismatch");
    endtask

    task automatic check_word(input string name, input rv64_pkg::xlen_t got,
                              input rv64_pkg::xlen_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_reg(input string name, input rv64_pkg::reg_addr_t got,
                             input rv64_pkg::reg_addr_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("[FAIL] t=%0t %s: got x%0d, expected x%0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("[FAIL] t=%0t %s: got %b, expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        reset_n = 1'b0;
        instr   = NOP;
        build_program();
        for (int r = 0; r < 4; r++) begin
            @(negedge clock);
            if (r % 2 == 0) begin
                instr = prog[r + 1]; // Register writes held off by reset
            end else begin
                instr = enc_s(12'd0, 5'd1, 5'd0, 3'b011); // Store held off by reset
            end
        end
        @(negedge clock);
        reset_n = 1'b1;
        instr   = fetch_word(pc);
        forever begin
            @(negedge clock);
            instr = fetch_word(pc); // Instruction memory lookup
        end
    end

    initial begin
        rv64_pkg::xlen_t     exp_pc;
        logic                exp_write;
        rv64_pkg::reg_addr_t exp_rd;
        rv64_pkg::xlen_t     exp_data;
        logic                done;
        mismatches = 0;
        done       = 1'b0;
        m_pc       = rv64_pkg::RESET_PC;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        while (!done) begin
            @(posedge clock);
            if (!reset_n) begin
                check_word("pc", pc, rv64_pkg::RESET_PC);
                check_bit("rd_write", rd_write, 1'b0);
            end else begin
                iss_step(fetch_word(m_pc), exp_pc, exp_write, exp_rd, exp_data);
                check_word("pc", pc, exp_pc);
                check_bit("rd_write", rd_write, exp_write);
                if (exp_write) begin
                    check_reg("rd_addr", rd_addr, exp_rd);
                    check_word("rd_data", rd_data, exp_data);
                end
                done = (m_pc >= END_PC);
            end
        end
        if (mismatches == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        int unsigned cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: program did not finish");
        $display(">>> FAIL");
        $fatal(1, "cycle limit reached");
    end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/rv64_pkg.sv
rtl/rv64_decoder.sv
rtl/rv64_regfile.sv
rtl/rv64_alu.sv
rtl/rv64_lsu.sv
rtl/rv64_fetch.sv
rtl/rv64_core.sv
verif/rv64_tb.sv
